// File: fetch_top.f
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/icache_tag_stage.sv
hdl/icache_data_stage.sv
hdl/icache_refill.sv
hdl/fetch_top.sv
sim/fetch_mem_model.sv
sim/fetch_tb.sv

// File: hdl/fetch_pc_gen.sv
`timescale 1ns/100ps

module fetch_pc_gen #(
	parameter fetch_pkg::addr_t RESET_PC = 32'h0000_1000,
	parameter int CREDITS = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic redirect,
	input  fetch_pkg::addr_t redirect_pc,
	input  logic lookup_hit,
	input  logic credit_return,
	output logic lookup_valid,
	output fetch_pkg::addr_t lookup_pc
);

	// counter must hold the full credit count
	localparam int CNT_W = $clog2(CREDITS + 1);

	fetch_pkg::addr_t pc;
	logic [CNT_W-1:0] credit_cnt;
	logic running;
	logic accept;

	// lookups start one cycle out of reset
	assign lookup_valid = running && (credit_cnt != '0);
	assign lookup_pc = pc;

	// a hit in a redirect cycle is dropped by the data stage,
	// so no credit is spent for it
	assign accept = lookup_hit && !redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
		end else begin
			running <= 1'b1;
		end
	end

	// redirect wins over sequential advance
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (accept) begin
			pc <= pc + fetch_pkg::addr_t'(4);
		end
		// on a miss the pc holds and the lookup repeats
	end

	// spend on accept, refund on credit_return, both may coincide
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_cnt <= CNT_W'(CREDITS);
		end else begin
			credit_cnt <= credit_cnt + CNT_W'(credit_return) - CNT_W'(accept);
		end
	end

endmodule

// File: hdl/fetch_pkg.sv
package fetch_pkg;

	// basic widths of the fetch path
	localparam int ADDR_W = 32;
	localparam int INST_W = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_W = INST_W * WORDS_PER_LINE;

	// cache geometry
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 64;

	// address fields: byte offset in line, set index, tag
	localparam int OFFSET_W = 4;
	localparam int WORD_LSB = 2;
	localparam int WORD_SEL_W = 2;
	localparam int INDEX_LSB = OFFSET_W;
	localparam int INDEX_W = 6;
	localparam int TAG_LSB = INDEX_LSB + INDEX_W;
	localparam int TAG_W = ADDR_W - TAG_LSB;

	// fetch byte address
	typedef logic [ADDR_W-1:0] addr_t;
	// one instruction word
	typedef logic [INST_W-1:0] inst_t;
	// one cache line, word 0 in the low bits
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	// one-hot way select for hit, victim and fill
	typedef logic [NUM_WAYS-1:0] way_t;

	// miss handling states
	typedef enum logic [1:0] {
		REFILL_IDLE,
		REFILL_WAIT,
		REFILL_WRITE
	} refill_state_t;

endpackage

// File: hdl/fetch_top.sv
`timescale 1ns/100ps

module fetch_top #(
	parameter fetch_pkg::addr_t RESET_PC = 32'h0000_1000,
	parameter int CREDITS = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic redirect,
	input  fetch_pkg::addr_t redirect_pc,
	input  logic credit_return,
	input  logic mem_resp_valid,
	input  fetch_pkg::line_t mem_line,
	output logic inst_valid,
	output fetch_pkg::inst_t inst,
	output fetch_pkg::addr_t inst_pc,
	output logic mem_req,
	output fetch_pkg::addr_t mem_addr
);

	// pc stage to tag stage
	logic lookup_valid;
	fetch_pkg::addr_t lookup_pc;

	// tag stage results
	logic lookup_hit;
	fetch_pkg::way_t hit_way;
	logic miss;
	fetch_pkg::way_t victim_way;

	// refill stage to both arrays
	logic refill_busy;
	logic fill_en;
	fetch_pkg::way_t fill_way;
	fetch_pkg::index_t fill_index;
	fetch_pkg::line_t fill_line;

	fetch_pc_gen #(
		.RESET_PC(RESET_PC),
		.CREDITS(CREDITS)
	) pc_gen0 (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.lookup_hit(lookup_hit),
		.credit_return(credit_return),
		.lookup_valid(lookup_valid),
		.lookup_pc(lookup_pc)
	);

	icache_tag_stage tag0 (
		.clk(clk),
		.rst(rst),
		.lookup_valid(lookup_valid),
		.lookup_pc(lookup_pc),
		.refill_busy(refill_busy),
		.fill_en(fill_en),
		.fill_way(fill_way),
		.fill_index(fill_index),
		.lookup_hit(lookup_hit),
		.hit_way(hit_way),
		.miss(miss),
		.victim_way(victim_way)
	);

	icache_data_stage data0 (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.lookup_hit(lookup_hit),
		.hit_way(hit_way),
		.lookup_pc(lookup_pc),
		.fill_en(fill_en),
		.fill_way(fill_way),
		.fill_index(fill_index),
		.fill_line(fill_line),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_pc(inst_pc)
	);

	icache_refill refill0 (
		.clk(clk),
		.rst(rst),
		.miss(miss),
		.victim_way(victim_way),
		.lookup_pc(lookup_pc),
		.mem_resp_valid(mem_resp_valid),
		.mem_line(mem_line),
		.refill_busy(refill_busy),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.fill_en(fill_en),
		.fill_way(fill_way),
		.fill_index(fill_index),
		.fill_line(fill_line)
	);

endmodule

// File: hdl/icache_data_stage.sv
`timescale 1ns/100ps

module icache_data_stage (
	input  logic clk,
	input  logic rst,
	input  logic redirect,
	input  logic lookup_hit,
	input  fetch_pkg::way_t hit_way,
	input  fetch_pkg::addr_t lookup_pc,
	input  logic fill_en,
	input  fetch_pkg::way_t fill_way,
	input  fetch_pkg::index_t fill_index,
	input  fetch_pkg::line_t fill_line,
	output logic inst_valid,
	output fetch_pkg::inst_t inst,
	output fetch_pkg::addr_t inst_pc
);

	// one line array per way
	fetch_pkg::line_t line_mem [fetch_pkg::NUM_WAYS][fetch_pkg::NUM_SETS];

	fetch_pkg::index_t lookup_index;
	fetch_pkg::line_t hit_line;
	// output register toward decode
	fetch_pkg::line_t line_q;
	fetch_pkg::addr_t pc_q;
	logic valid_q;

	assign lookup_index = lookup_pc[fetch_pkg::INDEX_LSB +: fetch_pkg::INDEX_W];

	// fill writes the whole line into the victim way
	always_ff @(posedge clk) begin
		if (fill_en) begin
			for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					line_mem[w][fill_index] <= fill_line;
				end
			end
		end
	end

	// hit_way has at most one bit set so the OR of the selected ways is the hit line
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
			if (hit_way[w]) begin
				hit_line = hit_line | line_mem[w][lookup_index];
			end
		end
	end

	// a hit captures the line together with its pc
	always_ff @(posedge clk) begin
		if (lookup_hit) begin
			line_q <= hit_line;
			pc_q <= lookup_pc;
		end
	end

	// redirect kills whatever was looked up in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= lookup_hit && !redirect;
		end
	end

	assign inst_valid = valid_q;
	assign inst_pc = pc_q;
	// word select by pc bits 3..2
	assign inst = line_q[pc_q[fetch_pkg::WORD_LSB +: fetch_pkg::WORD_SEL_W] *
		fetch_pkg::INST_W +: fetch_pkg::INST_W];

endmodule

// File: hdl/icache_refill.sv
`timescale 1ns/100ps

module icache_refill (
	input  logic clk,
	input  logic rst,
	input  logic miss,
	input  fetch_pkg::way_t victim_way,
	input  fetch_pkg::addr_t lookup_pc,
	input  logic mem_resp_valid,
	input  fetch_pkg::line_t mem_line,
	output logic refill_busy,
	output logic mem_req,
	output fetch_pkg::addr_t mem_addr,
	output logic fill_en,
	output fetch_pkg::way_t fill_way,
	output fetch_pkg::index_t fill_index,
	output fetch_pkg::line_t fill_line
);

	fetch_pkg::refill_state_t state;

	// control: state and the one-cycle request pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fetch_pkg::REFILL_IDLE;
			mem_req <= 1'b0;
		end else begin
			mem_req <= 1'b0;
			case (state)
				fetch_pkg::REFILL_IDLE: begin
					if (miss) begin
						state <= fetch_pkg::REFILL_WAIT;
						mem_req <= 1'b1;
					end
				end
				// wait for the memory, latency not fixed
				fetch_pkg::REFILL_WAIT: begin
					if (mem_resp_valid) begin
						state <= fetch_pkg::REFILL_WRITE;
					end
				end
				fetch_pkg::REFILL_WRITE: begin
					state <= fetch_pkg::REFILL_IDLE;
				end
				default: begin
					state <= fetch_pkg::REFILL_IDLE;
				end
			endcase
		end
	end

	// line address and victim are taken when the miss is accepted
	always_ff @(posedge clk) begin
		if (state == fetch_pkg::REFILL_IDLE && miss) begin
			mem_addr <= {lookup_pc[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W],
				{fetch_pkg::OFFSET_W{1'b0}}};
			fill_way <= victim_way;
		end
		if (state == fetch_pkg::REFILL_WAIT && mem_resp_valid) begin
			fill_line <= mem_line;
		end
	end

	assign refill_busy = (state != fetch_pkg::REFILL_IDLE);
	// write strobe to both arrays, one cycle after the response
	assign fill_en = (state == fetch_pkg::REFILL_WRITE);
	assign fill_index = mem_addr[fetch_pkg::INDEX_LSB +: fetch_pkg::INDEX_W];

endmodule

// File: hdl/icache_tag_stage.sv
`timescale 1ns/100ps

module icache_tag_stage (
	input  logic clk,
	input  logic rst,
	input  logic lookup_valid,
	input  fetch_pkg::addr_t lookup_pc,
	input  logic refill_busy,
	input  logic fill_en,
	input  fetch_pkg::way_t fill_way,
	input  fetch_pkg::index_t fill_index,
	output logic lookup_hit,
	output fetch_pkg::way_t hit_way,
	output logic miss,
	output fetch_pkg::way_t victim_way
);

	// tag array, one entry per way and set
	fetch_pkg::tag_t tag_mem [fetch_pkg::NUM_WAYS][fetch_pkg::NUM_SETS];
	// valid bits, one vector of sets per way
	logic [fetch_pkg::NUM_SETS-1:0] valid_bits [fetch_pkg::NUM_WAYS];

	// tag of the line under refill, written at fill time
	fetch_pkg::tag_t miss_tag;
	fetch_pkg::tag_t lookup_tag;
	fetch_pkg::index_t lookup_index;

	assign lookup_tag = lookup_pc[fetch_pkg::TAG_LSB +: fetch_pkg::TAG_W];
	assign lookup_index = lookup_pc[fetch_pkg::INDEX_LSB +: fetch_pkg::INDEX_W];

	// four-way compare against the indexed set
	always_comb begin
		for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
			hit_way[w] = valid_bits[w][lookup_index] &&
				(tag_mem[w][lookup_index] == lookup_tag);
		end
	end

	assign lookup_hit = lookup_valid && (hit_way != '0);

	// only one refill at a time, so hold miss off while busy
	assign miss = lookup_valid && (hit_way == '0) && !refill_busy;

	// refill stage is idle whenever miss is raised, so it takes this line
	always_ff @(posedge clk) begin
		if (miss) begin
			miss_tag <= lookup_tag;
		end
	end

	// tag write on fill into the victim way
	always_ff @(posedge clk) begin
		if (fill_en) begin
			for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					tag_mem[w][fill_index] <= miss_tag;
				end
			end
		end
	end

	// valid bits clear on reset, set by fill
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else if (fill_en) begin
			for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					valid_bits[w][fill_index] <= 1'b1;
				end
			end
		end
	end

	// rotating one-hot victim, starts at way 0, moves once per fill
	always_ff @(posedge clk) begin
		if (rst) begin
			victim_way <= fetch_pkg::way_t'(1);
		end else if (fill_en) begin
			victim_way <= {victim_way[fetch_pkg::NUM_WAYS-2:0],
				victim_way[fetch_pkg::NUM_WAYS-1]};
		end
	end

endmodule

// File: sim/fetch_mem_model.sv
`timescale 1ns/100ps

module fetch_mem_model (
	input  logic clk,
	input  logic mem_req,
	input  fetch_pkg::addr_t mem_addr,
	output logic mem_resp_valid,
	output fetch_pkg::line_t mem_line
);

	logic busy;
	int wait_cnt;
	fetch_pkg::addr_t line_addr;

	// word i of a line holds its own byte address xor a fixed key
	function automatic fetch_pkg::line_t make_line(input fetch_pkg::addr_t addr);
		fetch_pkg::line_t data;
		for (int i = 0; i < 4; i++) begin
			data[i*32 +: 32] = (addr + 32'(4 * i)) ^ 32'hA5A5A5A5;
		end
		return data;
	endfunction

	initial begin
		mem_resp_valid = 1'b0;
		mem_line = '0;
		busy = 1'b0;
		wait_cnt = 0;
	end

	// response changes 1 ns after the rising edge
	always @(posedge clk) begin
		#1;
		mem_resp_valid = 1'b0;
		if (busy) begin
			if (wait_cnt == 1) begin
				mem_resp_valid = 1'b1;
				mem_line = make_line(line_addr);
				busy = 1'b0;
			end else begin
				wait_cnt--;
			end
		end
		// new request, answered 1 to 8 cycles later
		if (mem_req) begin
			busy = 1'b1;
			line_addr = mem_addr;
			wait_cnt = $urandom_range(8, 1);
		end
	end

endmodule

// File: sim/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

	localparam int NUM_REDIRECTS = 400;
	localparam int STALL_LIMIT = 100;
	// 60 cycles of 8 ns per redirect
	localparam int RUN_LIMIT_NS = NUM_REDIRECTS * 60 * 8;
	localparam fetch_pkg::addr_t WINDOW_BASE = 32'h0000_4000;
	localparam fetch_pkg::inst_t XOR_KEY = 32'hA5A5A5A5;

	logic clk;
	logic rst;
	logic redirect;
	fetch_pkg::addr_t redirect_pc;
	logic credit_return;
	logic mem_resp_valid;
	fetch_pkg::line_t mem_line;
	logic inst_valid;
	fetch_pkg::inst_t inst;
	fetch_pkg::addr_t inst_pc;
	logic mem_req;
	fetch_pkg::addr_t mem_addr;

	// cache model with tags and valid bits per way and set and one global victim
	logic [21:0] model_tag [4][64];
	logic model_valid [4][64];
	int victim;
	fetch_pkg::addr_t expect_pc;
	// decode buffer fill level
	int held;
	int stall;
	int gap;
	int redirects_done;
	int delivered;
	int cyc;
	bit req_open;
	fetch_pkg::addr_t req_addr;
	bit fill_pending;
	fetch_pkg::addr_t fill_addr;
	int fill_cycle;
	bit enough_delivered;

	fetch_top #(
		.RESET_PC(32'h0000_1000),
		.CREDITS(4)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.credit_return(credit_return),
		.mem_resp_valid(mem_resp_valid),
		.mem_line(mem_line),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_pc(inst_pc),
		.mem_req(mem_req),
		.mem_addr(mem_addr)
	);

	fetch_mem_model mem0 (
		.clk(clk),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_resp_valid(mem_resp_valid),
		.mem_line(mem_line)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic require(input bit ok, input string what);
		assert (ok) else begin
			$display("CHECK FAILED at %0t ns: %s", $time, what);
			abort_run();
		end
	endtask

	// index is bits 9..4, tag is bits 31..10
	function automatic bit line_present(input fetch_pkg::addr_t addr);
		bit found;
		found = 1'b0;
		for (int w = 0; w < 4; w++) begin
			if (model_valid[w][addr[9:4]] && model_tag[w][addr[9:4]] == addr[31:10]) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// fill goes to the victim way, victim then moves on by one
	task automatic model_fill(input fetch_pkg::addr_t addr);
		model_tag[victim][addr[9:4]] = addr[31:10];
		model_valid[victim][addr[9:4]] = 1'b1;
		victim = (victim + 1) % 4;
	endtask

	// drives one cycle of decode credits and redirects 1 ns after the edge
	task automatic drive_cycle(input bit allow_redirect);
		@(posedge clk);
		#1;
		redirect = 1'b0;
		credit_return = 1'b0;
		if (held > 0 && $urandom_range(1, 0) == 1) begin
			credit_return = 1'b1;
		end
		if (allow_redirect) begin
			if (gap == 0) begin
				redirect = 1'b1;
				redirect_pc = WINDOW_BASE | ($urandom_range(1023, 0) << 2);
				redirects_done++;
				gap = $urandom_range(40, 2);
			end else begin
				gap--;
			end
		end
	endtask

	initial begin
		void'($urandom(94616));
		rst = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		credit_return = 1'b0;
		victim = 0;
		expect_pc = 32'h0000_1000;
		held = 0;
		stall = 0;
		redirects_done = 0;
		delivered = 0;
		cyc = 0;
		req_open = 1'b0;
		fill_pending = 1'b0;
		gap = $urandom_range(40, 2);
		for (int w = 0; w < 4; w++) begin
			for (int s = 0; s < 64; s++) begin
				model_valid[w][s] = 1'b0;
			end
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		while (redirects_done < NUM_REDIRECTS) begin
			drive_cycle(1'b1);
		end
		// drain while decode keeps returning credits
		repeat (100) begin
			drive_cycle(1'b0);
		end
		enough_delivered = (delivered > NUM_REDIRECTS);
		assert (enough_delivered) else begin
			$display("CHECK FAILED at %0t ns: only %0d instructions delivered",
				$time, delivered);
		end
		if (enough_delivered) begin
			$display("Test passed");
			$finish;
		end else begin
			abort_run();
		end
	end

	// all outputs sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			cyc++;
			// a filled line can first be delivered three cycles after the response
			if (fill_pending && cyc == fill_cycle) begin
				model_fill(fill_addr);
				fill_pending = 1'b0;
			end
			if (inst_valid) begin
				require(inst == (inst_pc ^ XOR_KEY),
					$sformatf("inst %h at pc %h", inst, inst_pc));
				require(inst_pc == expect_pc,
					$sformatf("inst_pc %h, expected %h", inst_pc, expect_pc));
				require(line_present(inst_pc),
					$sformatf("pc %h delivered but not in the cache model", inst_pc));
				expect_pc = inst_pc + 32'd4;
				held++;
				delivered++;
				stall = 0;
			end else begin
				stall++;
			end
			require(held <= 4, $sformatf("decode buffer holds %0d entries", held));
			if (credit_return) begin
				held--;
			end
			if (mem_req) begin
				require(mem_addr[3:0] == 4'h0, $sformatf("mem_addr %h not aligned", mem_addr));
				require(!req_open, "second mem_req before the response");
				require(!line_present(mem_addr),
					$sformatf("mem_req for line %h already cached", mem_addr));
				req_open = 1'b1;
				req_addr = mem_addr;
			end
			if (mem_resp_valid) begin
				req_open = 1'b0;
				fill_pending = 1'b1;
				fill_addr = req_addr;
				fill_cycle = cyc + 3;
			end
			// new stream starts in the next cycle
			if (redirect) begin
				expect_pc = redirect_pc;
			end
			assert (stall < STALL_LIMIT) else begin
				$display("no instruction delivered for %0d cycles at %0t ns", STALL_LIMIT, $time);
				abort_run();
			end
		end
	end

	initial begin
		#(RUN_LIMIT_NS);
		$display("timeout: the run did not reach its end in time");
		abort_run();
	end

endmodule
